/* bench/fetch_branch_model.svh */
logic [31:0] shadow_regs [32];
logic [31:0] shadow_pc;
logic [31:0] program_map [logic [31:0]];  // Instruction memory by byte address

task automatic model_reset();
    for (int i = 0; i < 32; i++) begin
        shadow_regs[i] = '0;
    end
    shadow_pc = reset_vector;
endtask

function automatic logic compare_rule(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
        funct3_beq:  return a == b;
        funct3_bne:  return a != b;
        funct3_blt:  return $signed(a) < $signed(b);
        funct3_bge:  return $signed(a) >= $signed(b);
        funct3_bltu: return a < b;
        funct3_bgeu: return a >= b;
        default:     return 1'b0;
    endcase
endfunction

// Immediates straight from the ISA bit positions
function automatic logic [31:0] b_immediate(input logic [31:0] w);
    return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
endfunction

function automatic logic [31:0] j_immediate(input logic [31:0] w);
    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
endfunction

function automatic logic model_taken(input logic [31:0] w);
    return (w[6:0] == opcode_branch) &&
           compare_rule(w[14:12], shadow_regs[w[19:15]], shadow_regs[w[24:20]]);
endfunction

task automatic model_step(input logic valid, input logic [31:0] w, input logic ld_en,
                          input logic [4:0] ld_idx, input logic [31:0] ld_val);
    logic [31:0] next_pc;
    logic        is_jal;
    is_jal  = valid && (w[6:0] == opcode_jal);
    next_pc = shadow_pc + pc_step;
    if (valid && model_taken(w)) begin
        next_pc = shadow_pc + b_immediate(w);
    end
    if (is_jal) begin
        next_pc = shadow_pc + j_immediate(w);
    end
    if (ld_en && ld_idx != 0) begin
        shadow_regs[ld_idx] = ld_val;
    end
    if (is_jal && w[11:7] != 0) begin
        shadow_regs[w[11:7]] = shadow_pc + pc_step;  // Link beats load
    end
    if (valid) begin
        shadow_pc = next_pc;
    end
endtask

function automatic logic [31:0] make_branch(input logic [2:0] f3, input logic [4:0] rs1,
                                            input logic [4:0] rs2, input logic [31:0] off);
    instr_t w;
    w.b_view.imm12   = off[12];
    w.b_view.imm10_5 = off[10:5];
    w.b_view.rs2     = rs2;
    w.b_view.rs1     = rs1;
    w.b_view.funct3  = f3;
    w.b_view.imm4_1  = off[4:1];
    w.b_view.imm11   = off[11];
    w.b_view.opcode  = opcode_branch;
    return w;
endfunction

function automatic logic [31:0] make_jal(input logic [4:0] rd, input logic [31:0] off);
    instr_t w;
    w.j_view.imm20    = off[20];
    w.j_view.imm10_1  = off[10:1];
    w.j_view.imm11    = off[11];
    w.j_view.imm19_12 = off[19:12];
    w.j_view.rd       = rd;
    w.j_view.opcode   = opcode_jal;
    return w;
endfunction

/* bench/fetch_branch_tb.sv */
`timescale 1ns/1ps

module fetch_branch_tb
    import riscv_isa_pkg::*;
    import core_cfg_pkg::*;
();

    localparam int clk_period      = 100;
    localparam int seq_cycles      = 40;
    localparam int branch_rounds   = 48;
    localparam int jal_rounds      = 16;
    localparam int priority_rounds = 12;
    localparam int test_cycles     = 10 + 4 + seq_cycles + 3 * branch_rounds
                                     + 3 * jal_rounds + 3 * priority_rounds + 1;
    localparam int margin_cycles   = 50;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic        load_enable;
    logic [4:0]  load_index;
    logic [31:0] load_value;
    logic [31:0] pc;
    logic        branch_taken;

    int   pass_count;
    int   error_count;
    int   test_pass_start;
    int   test_error_start;
    logic last_taken;

    `include "fetch_branch_model.svh"

    fetch_branch_top u_fetch_branch_top (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .load_enable  (load_enable),
        .load_index   (load_index),
        .load_value   (load_value),
        .pc           (pc),
        .branch_taken (branch_taken)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] make_other();
        logic [31:0] w;
        w = $urandom;
        if (w[6:0] == opcode_branch || w[6:0] == opcode_jal) begin
            w[6:0] = 7'b0010011;  // OP-IMM instead
        end
        return w;
    endfunction

    function automatic logic [2:0] random_funct3();
        case ($urandom_range(5, 0))
            0:       return funct3_beq;
            1:       return funct3_bne;
            2:       return funct3_blt;
            3:       return funct3_bge;
            4:       return funct3_bltu;
            default: return funct3_bgeu;
        endcase
    endfunction

    function automatic logic [31:0] branch_offset();
        return ($urandom_range(255, 0) - 128) << 2;  // -512 .. 508
    endfunction

    function automatic logic [31:0] jal_offset();
        return ($urandom_range(1023, 0) - 512) << 2;
    endfunction

    function automatic logic [31:0] random_word();
        case ($urandom_range(2, 0))
            0:       return make_branch(random_funct3(), $urandom, $urandom, branch_offset());
            1:       return make_jal($urandom, jal_offset());
            default: return make_other();
        endcase
    endfunction

    // Lazy fill on first fetch
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        if (!program_map.exists(addr)) begin
            program_map[addr] = random_word();
        end
        return program_map[addr];
    endfunction

    // Edge cases for signed versus unsigned order
    function automatic logic [31:0] pick_operand();
        case ($urandom_range(6, 0))
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'hffff_ffff;
            3:       return 32'h7fff_ffff;
            4:       return 32'h8000_0000;
            5:       return 32'h8000_0001;
            default: return $urandom;
        endcase
    endfunction

    task automatic check_word(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        assert (actual === expected) pass_count++;
        else begin
            error_count++;
            $display("MISMATCH at %0d ns: %s dut=%h expected=%h", $time, name, actual,
                     expected);
        end
    endtask

    task automatic run_cycle(input logic valid, input logic ld_en, input logic [4:0] ld_idx,
                             input logic [31:0] ld_val);
        logic [31:0] word;
        logic        exp_taken;
        @(posedge clk);
        #5;
        word        = word_at(pc);
        instr_valid = valid;
        instr       = word;
        load_enable = ld_en;
        load_index  = ld_idx;
        load_value  = ld_val;
        @(negedge clk);
        exp_taken = valid && model_taken(word);
        check_word("pc", pc, shadow_pc);
        check_word("branch_taken", {31'b0, branch_taken}, {31'b0, exp_taken});
        last_taken = branch_taken;
        model_step(valid, word, ld_en, ld_idx, ld_val);
    endtask

    task automatic start_test();
        test_pass_start  = pass_count;
        test_error_start = error_count;
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: %0d checks passed, %0d errors", num, name,
                 pass_count - test_pass_start, error_count - test_error_start);
    endtask

    initial begin
        #((test_cycles + margin_cycles) * clk_period);
        $display("Run timed out after %0d cycles without finishing the tests",
                 test_cycles + margin_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        logic [4:0]  x;
        logic [4:0]  y;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] link;
        void'($urandom(32'h42f70022));
        pass_count  = 0;
        error_count = 0;
        last_taken  = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        load_enable = 1'b0;
        load_index  = '0;
        load_value  = '0;
        model_reset();
        repeat (10) @(posedge clk);
        #5;
        reset = 1'b0;

        start_test();
        program_map[shadow_pc] = make_branch(funct3_beq, 5'd0, 5'd0, 32'd8);  // Would be taken
        repeat (4) run_cycle(1'b0, 1'b0, 5'd0, 32'd0);
        report_test(1, "reset state");

        start_test();
        for (int i = 0; i < seq_cycles; i++) begin
            program_map[shadow_pc] = make_other();
            run_cycle($urandom_range(3, 0) != 0, 1'b0, 5'd0, 32'd0);
        end
        report_test(2, "sequential fetch with holds");

        start_test();
        for (int i = 0; i < branch_rounds; i++) begin
            x = $urandom_range(31, 1);
            y = $urandom_range(31, 1);
            a = pick_operand();
            b = ($urandom_range(3, 0) == 0) ? a : pick_operand();
            run_cycle(1'b0, 1'b1, x, a);
            run_cycle(1'b1, 1'b1, y, b);  // Random word from the program
            program_map[shadow_pc] = make_branch(random_funct3(), x, y, branch_offset());
            run_cycle(1'b1, 1'b0, 5'd0, 32'd0);
        end
        report_test(3, "branch compares");

        start_test();
        for (int i = 0; i < jal_rounds; i++) begin
            x    = (i % 4 == 0) ? 5'd0 : 5'($urandom_range(31, 1));
            y    = (x == 5'd31) ? 5'd30 : x + 5'd1;
            link = shadow_pc + pc_step;
            program_map[shadow_pc] = make_jal(x, jal_offset());
            run_cycle(1'b1, 1'b0, 5'd0, 32'd0);
            run_cycle(1'b0, 1'b1, y, (x == 5'd0) ? 32'd0 : link);
            program_map[shadow_pc] = make_branch(funct3_beq, x, y, branch_offset());
            run_cycle(1'b1, 1'b0, 5'd0, 32'd0);
            check_word("branch_taken after link", {31'b0, last_taken}, 32'd1);
        end
        report_test(4, "jal and link");

        start_test();
        for (int i = 0; i < priority_rounds; i++) begin
            x    = $urandom_range(31, 1);
            y    = (x == 5'd31) ? 5'd30 : x + 5'd1;
            link = shadow_pc + pc_step;
            program_map[shadow_pc] = make_jal(x, jal_offset());
            run_cycle(1'b1, 1'b1, x, ~link);  // Load and link hit the same rd
            run_cycle(1'b0, 1'b1, y, link);
            program_map[shadow_pc] = make_branch(funct3_beq, x, y, branch_offset());
            run_cycle(1'b1, 1'b0, 5'd0, 32'd0);
            check_word("branch_taken after shared write", {31'b0, last_taken}, 32'd1);
        end
        report_test(5, "link over load priority");

        run_cycle(1'b0, 1'b0, 5'd0, 32'd0);  // Last redirect target
        $display("checks passed: %0d, errors: %0d", pass_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+bench
source/riscv_isa_pkg.sv
source/core_cfg_pkg.sv
source/branch_unit.sv
source/instruction_decoder.sv
source/register_file.sv
source/fetch_unit.sv
source/fetch_branch_top.sv
bench/fetch_branch_tb.sv

/* source/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit
    import riscv_isa_pkg::*;
(
    input  logic [2:0]      funct3,
    input  logic            branch_signal,  // From decoder
    input  logic [xlen-1:0] bus_rs1,
    input  logic [xlen-1:0] bus_rs2,
    output logic            branch_enable   // To fetch unit
);

    logic rs_equal;
    logic rs_less_signed;
    logic rs_less_unsigned;

    assign rs_equal         = (bus_rs1 == bus_rs2);
    assign rs_less_signed   = ($signed(bus_rs1) < $signed(bus_rs2));
    assign rs_less_unsigned = (bus_rs1 < bus_rs2);

    always_comb begin
        branch_enable = 1'b0;
        if (branch_signal) begin
            case (funct3)
                funct3_beq:  branch_enable = rs_equal;
                funct3_bne:  branch_enable = !rs_equal;
                funct3_blt:  branch_enable = rs_less_signed;
                funct3_bge:  branch_enable = !rs_less_signed;
                funct3_bltu: branch_enable = rs_less_unsigned;
                funct3_bgeu: branch_enable = !rs_less_unsigned;
                default:     branch_enable = 1'b0;  // 010, 011 unused
            endcase
        end
    end

    // Operands of opposite sign order by the sign bit alone
    blt_by_sign: assert final (
        !(branch_signal && funct3 == funct3_blt && bus_rs1[xlen-1] != bus_rs2[xlen-1]) ||
        (branch_enable == bus_rs1[xlen-1])
    ) else $error("blt result disagrees with the operand signs");

endmodule

/* source/core_cfg_pkg.sv */
package core_cfg_pkg;

    // Address of the first fetch
    localparam logic [31:0] reset_vector = 32'h0000_0000;

    localparam int reg_count       = 32;
    localparam int reg_index_width = 5;

    // Sequential fetch increment in bytes
    localparam logic [31:0] pc_step = 32'd4;

endpackage

/* source/fetch_branch_top.sv */
`timescale 1ns/1ps

module fetch_branch_top
    import riscv_isa_pkg::*;
    import core_cfg_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       instr_valid,
    input  logic [xlen-1:0]            instr,
    input  logic                       load_enable,
    input  logic [reg_index_width-1:0] load_index,
    input  logic [xlen-1:0]            load_value,
    output logic [xlen-1:0]            pc,
    output logic                       branch_taken
);

    logic                       branch_signal;
    logic                       jump_signal;
    logic                       link_enable;
    logic [2:0]                 funct3;
    logic [reg_index_width-1:0] rs1_index;
    logic [reg_index_width-1:0] rs2_index;
    logic [reg_index_width-1:0] link_index;
    logic [xlen-1:0]            link_value;
    logic [xlen-1:0]            offset;
    logic [xlen-1:0]            bus_rs1;
    logic [xlen-1:0]            bus_rs2;
    logic                       branch_enable;

    instruction_decoder u_instruction_decoder (
        .instr         (instr),
        .instr_valid   (instr_valid),
        .pc            (pc),
        .branch_signal (branch_signal),
        .jump_signal   (jump_signal),
        .link_enable   (link_enable),
        .funct3        (funct3),
        .rs1_index     (rs1_index),
        .rs2_index     (rs2_index),
        .link_index    (link_index),
        .link_value    (link_value),
        .offset        (offset)
    );

    register_file u_register_file (
        .clk         (clk),
        .reset       (reset),
        .rs1_index   (rs1_index),
        .rs2_index   (rs2_index),
        .bus_rs1     (bus_rs1),
        .bus_rs2     (bus_rs2),
        .link_enable (link_enable),
        .link_index  (link_index),
        .link_value  (link_value),
        .load_enable (load_enable),
        .load_index  (load_index),
        .load_value  (load_value)
    );

    branch_unit u_branch_unit (
        .funct3        (funct3),
        .branch_signal (branch_signal),
        .bus_rs1       (bus_rs1),
        .bus_rs2       (bus_rs2),
        .branch_enable (branch_enable)
    );

    fetch_unit u_fetch_unit (
        .clk           (clk),
        .reset         (reset),
        .instr_valid   (instr_valid),
        .branch_enable (branch_enable),
        .jump_signal   (jump_signal),
        .offset        (offset),
        .pc            (pc)
    );

    assign branch_taken = branch_enable;  // Same cycle as the word

endmodule

/* source/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit
    import riscv_isa_pkg::*;
    import core_cfg_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            instr_valid,
    input  logic            branch_enable,  // Taken conditional branch
    input  logic            jump_signal,    // JAL
    input  logic [xlen-1:0] offset,
    output logic [xlen-1:0] pc
);

    logic            redirect;
    logic [xlen-1:0] pc_increment;

    assign redirect = branch_enable || jump_signal;

    always_comb begin
        pc_increment = pc_step;
        if (redirect) begin
            pc_increment = offset;  // Relative to current word
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_vector;
        end else if (instr_valid) begin
            pc <= pc + pc_increment;
        end
    end

    // Decoder offsets and the reset vector keep word alignment
    pc_word_aligned: assert property (
        @(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00
    ) else $error("pc lost 4-byte alignment: %h", pc);

endmodule

/* source/instruction_decoder.sv */
`timescale 1ns/1ps

module instruction_decoder
    import riscv_isa_pkg::*;
    import core_cfg_pkg::*;
(
    input  instr_t                     instr,
    input  logic                       instr_valid,
    input  logic [xlen-1:0]            pc,
    output logic                       branch_signal,
    output logic                       jump_signal,
    output logic                       link_enable,
    output logic [2:0]                 funct3,
    output logic [reg_index_width-1:0] rs1_index,
    output logic [reg_index_width-1:0] rs2_index,
    output logic [reg_index_width-1:0] link_index,
    output logic [xlen-1:0]            link_value,
    output logic [xlen-1:0]            offset
);

    logic            is_branch;
    logic            is_jal;
    logic [xlen-1:0] b_imm;
    logic [xlen-1:0] j_imm;

    // Opcode field sits in the same bits in both views
    assign is_branch = instr_valid && (instr.b_view.opcode == opcode_branch);
    assign is_jal    = instr_valid && (instr.j_view.opcode == opcode_jal);

    // Register fields come straight from the word
    assign funct3     = instr.b_view.funct3;
    assign rs1_index  = instr.b_view.rs1;
    assign rs2_index  = instr.b_view.rs2;
    assign link_index = instr.j_view.rd;

    // B-immediate with bit 0 always zero
    assign b_imm = {
        {19{instr.b_view.imm12}},
        instr.b_view.imm12,
        instr.b_view.imm11,
        instr.b_view.imm10_5,
        instr.b_view.imm4_1,
        1'b0
    };

    // J-immediate with bit 0 always zero
    assign j_imm = {
        {11{instr.j_view.imm20}},
        instr.j_view.imm20,
        instr.j_view.imm19_12,
        instr.j_view.imm11,
        instr.j_view.imm10_1,
        1'b0
    };

    always_comb begin
        offset = b_imm;
        if (is_jal) begin
            offset = j_imm;
        end
    end

    assign branch_signal = is_branch;
    assign jump_signal   = is_jal;

    // Return address goes to rd unless rd is x0
    assign link_enable = is_jal && (instr.j_view.rd != '0);
    assign link_value  = pc + pc_step;

    // Union layout against the ISA bit positions of imm[11]
    imm11_bit_source: assert final (
        !(branch_signal || jump_signal) ||
        (offset[11] == (jump_signal ? instr[20] : instr[7]))
    ) else $error("offset bit 11 does not match the instruction word");

endmodule

/* source/register_file.sv */
`timescale 1ns/1ps

module register_file
    import riscv_isa_pkg::*;
    import core_cfg_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic [reg_index_width-1:0] rs1_index,
    input  logic [reg_index_width-1:0] rs2_index,
    output logic [xlen-1:0]            bus_rs1,
    output logic [xlen-1:0]            bus_rs2,
    input  logic                       link_enable,
    input  logic [reg_index_width-1:0] link_index,
    input  logic [xlen-1:0]            link_value,
    input  logic                       load_enable,
    input  logic [reg_index_width-1:0] load_index,
    input  logic [xlen-1:0]            load_value
);

    logic [xlen-1:0] regs [reg_count];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (load_enable && load_index != '0) begin
                regs[load_index] <= load_value;
            end
            // Issued last so it wins on a shared index
            if (link_enable && link_index != '0) begin
                regs[link_index] <= link_value;
            end
        end
    end

    assign bus_rs1 = regs[rs1_index];  // x0 never written
    assign bus_rs2 = regs[rs2_index];

    x0_reads_zero: assert property (
        @(posedge clk) disable iff (reset)
        ((rs1_index == '0) |-> (bus_rs1 == '0)) and
        ((rs2_index == '0) |-> (bus_rs2 == '0))
    ) else $error("x0 read returned a nonzero value");

endmodule

/* source/riscv_isa_pkg.sv */
package riscv_isa_pkg;

    localparam int xlen = 32;

    // Major opcodes handled by this slice
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_jal    = 7'b1101111;

    // B-type compare selectors
    localparam logic [2:0] funct3_beq  = 3'b000;
    localparam logic [2:0] funct3_bne  = 3'b001;
    localparam logic [2:0] funct3_blt  = 3'b100;
    localparam logic [2:0] funct3_bge  = 3'b101;
    localparam logic [2:0] funct3_bltu = 3'b110;
    localparam logic [2:0] funct3_bgeu = 3'b111;

    // Same 32-bit word, read as a B-type or a J-type encoding
    typedef union packed {
        struct packed {
            logic       imm12;    // Sign bit
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b_view;
        struct packed {
            logic       imm20;    // Sign bit
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_view;
    } instr_t;

endpackage
